/* logic/boot_config.svh */
`ifndef BOOT_CONFIG_SVH
`define BOOT_CONFIG_SVH

////////////////////////////////////////
// SPI timing
////////////////////////////////////////

// System clocks per SPI half period, 25 MHz / 4 gives 6.25 MHz SCLK
`define BOOT_SPI_DIV 2

// SPI clocks with CS high before CMD0
`define BOOT_DUMMY_CLKS 80

////////////////////////////////////////
// SD image layout
////////////////////////////////////////

`define BOOT_BLOCK_BYTES 512  // Fixed SD block length
`define BOOT_IMG_BLOCKS 2048  // 1 MB per set, start block = set * this

////////////////////////////////////////
// FPGA configuration
////////////////////////////////////////

`define BOOT_PROG_CYCLES 50   // Program pulse, 2 us at 25 MHz

`endif

/* logic/boot_pkg.sv */
package boot_pkg;

   ////////////////////////////////////////
   // Width types
   ////////////////////////////////////////

   typedef logic [7:0]  byte_t;      // One SPI or config byte
   typedef logic [3:0]  set_sel_t;   // Image set number, 16 sets
   typedef logic [31:0] blk_addr_t;  // SD block address for CMD17

   ////////////////////////////////////////
   // Read controller states
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      rd_dummy,       // 80 clocks, CS high
      rd_cmd0,        // GO_IDLE_STATE frame
      rd_cmd17,       // READ_SINGLE_BLOCK frame
      rd_wait_r1,     // Poll for R1
      rd_wait_token,  // Poll for FE start token
      rd_data,        // Block payload
      rd_crc,         // Two CRC bytes, discarded
      rd_idle         // Card released
   } rd_state_t;

   // SD SPI pins as seen by one port
   typedef struct packed {
      logic sclk;  // Toward card
      logic cs_n;  // Toward card
      logic mosi;  // Toward card
      logic miso;  // From card
   } sd_bus_t;

endpackage

/* logic/spi_shifter.sv */
`include "boot_config.svh"

module spi_shifter
   import boot_pkg::*;
(
   input  logic    clk_i,
   input  logic    reset_i,
   input  logic    start_i,    // One-cycle launch
   input  byte_t   tx_byte_i,
   input  logic    cs_n_i,     // Chip select level from the owner
   output byte_t   rx_byte_o,
   output logic    done_o,     // One-cycle, rx_byte_o valid
   output logic    busy_o,
   output sd_bus_t bus_o,
   input  logic    miso_i
);

   localparam int div_w = ($clog2(`BOOT_SPI_DIV) > 0) ? $clog2(`BOOT_SPI_DIV) : 1;

   logic [div_w-1:0] div_cnt;   // Clocks inside one half period
   logic [3:0]       half_cnt;  // 16 half periods per byte
   logic             sclk_q;
   byte_t            tx_sh;     // MSB drives mosi
   byte_t            rx_sh;
   logic             half_tick;
   logic             rise_tick;

   assign half_tick = (div_cnt == div_w'(`BOOT_SPI_DIV - 1));
   assign rise_tick = busy_o && half_tick && !half_cnt[0];  // SCLK about to go high

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         busy_o   <= 1'b0;
         done_o   <= 1'b0;
         sclk_q   <= 1'b0;      // Mode 0 idles low
         div_cnt  <= '0;
         half_cnt <= '0;
         tx_sh    <= 8'hff;     // Mosi high between bytes
      end else begin
         done_o <= 1'b0;
         if (!busy_o) begin
            if (start_i) begin
               busy_o   <= 1'b1;
               tx_sh    <= tx_byte_i;
               div_cnt  <= '0;
               half_cnt <= '0;
            end
         end else if (half_tick) begin
            div_cnt  <= '0;
            half_cnt <= half_cnt + 4'd1;
            sclk_q   <= ~sclk_q;
            if (half_cnt[0]) begin
               tx_sh <= {tx_sh[6:0], 1'b1};  // Falling edge, next bit out
               if (half_cnt == 4'd15) begin
                  busy_o <= 1'b0;
                  done_o <= 1'b1;
               end
            end
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
      end
   end

   // Sample miso as SCLK rises
   always_ff @(posedge clk_i) begin
      if (rise_tick) begin
         rx_sh <= {rx_sh[6:0], miso_i};
      end
   end

   assign rx_byte_o    = rx_sh;
   assign bus_o.sclk   = sclk_q;
   assign bus_o.cs_n   = cs_n_i;
   assign bus_o.mosi   = tx_sh[7];
   assign bus_o.miso   = miso_i;  // Echo of the card line

   // Owner must wait for done before the next launch
   a_no_start_busy : assert property (@(posedge clk_i) disable iff (reset_i)
      busy_o |-> !start_i)
      else $error("spi_shifter: start while busy");

endmodule

/* logic/sd_read_ctrl.sv */
`include "boot_config.svh"

module sd_read_ctrl
   import boot_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,
   input  logic     enable_i,      // Loader saw init
   input  set_sel_t set_sel_i,
   input  logic     cfg_done_i,
   input  logic     sink_ready_i,  // Loader serializer empty
   output byte_t    byte_o,
   output logic     byte_valid_o,
   output logic     detached_o,
   output sd_bus_t  bus_o,
   input  logic     miso_i
);

   localparam int cnt_w       = $clog2(`BOOT_BLOCK_BYTES) + 1;
   localparam int dummy_bytes = `BOOT_DUMMY_CLKS / 8;

   rd_state_t        state;
   logic [cnt_w-1:0] cnt;        // Bytes within the current phase
   blk_addr_t        blk_addr;
   blk_addr_t        start_blk;
   logic             in_cmd17;   // Which command the R1 belongs to
   logic             launch;
   logic             blk_end;
   logic             cs_n;
   byte_t            tx_byte;
   byte_t            rx_byte;
   logic             spi_done;
   logic             spi_busy;
   logic [5:0][7:0]  cmd_frame;  // Byte 5 goes first

   assign start_blk = blk_addr_t'(set_sel_i) * blk_addr_t'(`BOOT_IMG_BLOCKS);
   assign cs_n      = (state == rd_dummy) || (state == rd_idle);
   assign blk_end   = spi_done && (state == rd_crc) && (cnt == cnt_w'(1));

   // CMD0 carries its real CRC and CMD17 only the stop bit
   assign cmd_frame = (state == rd_cmd17) ? {8'h51, blk_addr, 8'h01}
                                          : {8'h40, 32'h0, 8'h95};

   always_comb begin
      tx_byte = 8'hff;  // Dummy and polling filler
      if ((state == rd_cmd0) || (state == rd_cmd17)) begin
         tx_byte = cmd_frame[3'd5 - cnt[2:0]];
      end
   end

   // One byte at a time and only while the loader can take data
   assign launch = enable_i && !spi_busy && !spi_done && !byte_valid_o && sink_ready_i
                   && !cfg_done_i && (state != rd_idle);

   spi_shifter u_shifter (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .start_i   (launch),
      .tx_byte_i (tx_byte),
      .cs_n_i    (cs_n),
      .rx_byte_o (rx_byte),
      .done_o    (spi_done),
      .busy_o    (spi_busy),
      .bus_o     (bus_o),
      .miso_i    (miso_i)
   );

   ////////////////////////////////////////
   // Read sequence
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (reset_i || !enable_i) begin
         state        <= rd_dummy;
         cnt          <= '0;
         in_cmd17     <= 1'b0;
         byte_valid_o <= 1'b0;
         detached_o   <= 1'b0;
      end else begin
         byte_valid_o <= 1'b0;
         detached_o   <= (state == rd_idle);  // One cycle behind idle
         if (spi_done) begin
            cnt <= cnt + 1'b1;
            unique case (state)
               rd_dummy: if (cnt == cnt_w'(dummy_bytes - 1)) begin
                  state <= rd_cmd0;
                  cnt   <= '0;
               end
               rd_cmd0, rd_cmd17: if (cnt == cnt_w'(5)) begin
                  state <= rd_wait_r1;
                  cnt   <= '0;
               end
               rd_wait_r1: begin
                  cnt <= '0;
                  if (in_cmd17 && (rx_byte == 8'h00)) begin
                     state <= rd_wait_token;
                  end else if (!in_cmd17 && (rx_byte == 8'h01)) begin
                     state    <= rd_cmd17;  // Card idle so reading starts
                     in_cmd17 <= 1'b1;
                  end else if (rx_byte != 8'hff) begin
                     state <= in_cmd17 ? rd_cmd17 : rd_cmd0;  // Retry on error
                  end
               end
               rd_wait_token: begin
                  cnt <= '0;
                  if (rx_byte == 8'hfe) state <= rd_data;
               end
               rd_data: begin
                  byte_valid_o <= !cfg_done_i;
                  if (cnt == cnt_w'(`BOOT_BLOCK_BYTES - 1)) begin
                     state <= rd_crc;
                     cnt   <= '0;
                  end
               end
               rd_crc: if (blk_end) begin
                  state <= rd_cmd17;  // Next block
                  cnt   <= '0;
               end
               default: ;  // Idle holds
            endcase
         end
         if (cfg_done_i && !spi_busy) state <= rd_idle;  // Byte in flight finishes first
      end
   end

   always_ff @(posedge clk_i) begin
      if (!enable_i) begin
         blk_addr <= start_blk;
      end else if (blk_end) begin
         blk_addr <= blk_addr + 1'b1;
      end
      if (spi_done) byte_o <= rx_byte;
   end

   // Payload bytes only, each one into an empty serializer
   a_valid_in_data : assert property (@(posedge clk_i) disable iff (reset_i)
      byte_valid_o |-> ($past(state) == rd_data) && sink_ready_i)
      else $error("sd_read_ctrl: byte_valid_o outside data phase or into a busy loader");

endmodule

/* logic/cfg_loader.sv */
`include "boot_config.svh"

module cfg_loader
   import boot_pkg::*;
(
   input  logic  clk_i,
   input  logic  reset_i,
   input  byte_t byte_i,
   input  logic  byte_valid_i,
   output logic  ready_o,        // Serializer empty
   input  logic  cfg_init_n_i,
   output logic  config_n_o,     // FPGA program line
   output logic  cfg_clk_o,
   output logic  cfg_dat_o,
   output logic  read_enable_o   // Lets the SD reader run
);

   localparam int prog_w = $clog2(`BOOT_PROG_CYCLES + 1);

   logic [prog_w-1:0] prog_cnt;
   byte_t             ser_sh;    // MSB on cfg_dat_o
   logic [2:0]        bit_cnt;
   logic              ser_busy;
   logic              accept;

   ////////////////////////////////////////
   // Program pulse and init wait
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         config_n_o    <= 1'b0;   // Pulse starts with reset
         prog_cnt      <= '0;
         read_enable_o <= 1'b0;
      end else if (!config_n_o) begin
         prog_cnt <= prog_cnt + 1'b1;
         if (prog_cnt == prog_w'(`BOOT_PROG_CYCLES - 1)) config_n_o <= 1'b1;
      end else if (cfg_init_n_i) begin
         read_enable_o <= 1'b1;   // FPGA cleared its memory
      end
   end

   ////////////////////////////////////////
   // Bit serializer, two cycles per bit
   ////////////////////////////////////////

   assign accept  = byte_valid_i && !ser_busy;
   assign ready_o = !ser_busy;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ser_busy  <= 1'b0;
         cfg_clk_o <= 1'b0;
         bit_cnt   <= '0;
      end else if (!ser_busy) begin
         if (accept) begin
            ser_busy <= 1'b1;
            bit_cnt  <= '0;
         end
      end else if (!cfg_clk_o) begin
         cfg_clk_o <= 1'b1;       // Data settled a cycle ago
      end else begin
         cfg_clk_o <= 1'b0;
         bit_cnt   <= bit_cnt + 3'd1;
         if (bit_cnt == 3'd7) ser_busy <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         ser_sh <= byte_i;
      end else if (ser_busy && cfg_clk_o) begin
         ser_sh <= {ser_sh[6:0], 1'b0};  // Shift after the high phase
      end
   end

   assign cfg_dat_o = ser_sh[7];

   // No config clocks during the program pulse
   a_no_cclk_in_prog : assert property (@(posedge clk_i) disable iff (reset_i)
      !config_n_o |-> $stable(cfg_clk_o))
      else $error("cfg_loader: cfg_clk_o moved while config_n_o low");

endmodule

/* logic/sd_bus_arbiter.sv */
module sd_bus_arbiter
   import boot_pkg::*;
(
   input  logic    clk_i,
   input  logic    reset_i,
   input  logic    takeover_i,   // FPGA request for the card
   input  logic    detached_i,   // Boot engine released the card
   input  sd_bus_t boot_bus_i,
   input  sd_bus_t fpga_bus_i,
   output sd_bus_t sd_bus_o,     // Pin side
   input  logic    miso_i,
   output logic    granted_o
);

   // Grant is sticky until reset
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         granted_o <= 1'b0;
      end else if (takeover_i && detached_i) begin
         granted_o <= 1'b1;
      end
   end

   ////////////////////////////////////////
   // Pin mux
   ////////////////////////////////////////

   always_comb begin
      sd_bus_o      = granted_o ? fpga_bus_i : boot_bus_i;
      sd_bus_o.miso = miso_i;   // Card output reaches both peers
   end

   // Boot engine must be off the pins before the FPGA gets them
   a_grant_after_detach : assert property (@(posedge clk_i) disable iff (reset_i)
      granted_o |-> detached_i)
      else $error("sd_bus_arbiter: grant without detached");

endmodule

/* logic/boot_cpld.sv */
module boot_cpld
   import boot_pkg::*;
(
   input  logic     clk_i,          // 25 MHz board clock
   input  logic     reset_i,
   input  set_sel_t set_sel_i,

   // SD card, SPI mode
   output logic     sd_sclk_o,
   output logic     sd_cs_n_o,
   output logic     sd_mosi_o,
   input  logic     sd_miso_i,

   // FPGA serial configuration
   input  logic     cfg_init_n_i,
   input  logic     cfg_done_i,
   output logic     config_n_o,
   output logic     cfg_clk_o,
   output logic     cfg_dat_o,

   // FPGA access to the card after boot
   output logic     detached_o,
   input  logic     takeover_i,
   input  logic     fpga_sclk_i,
   input  logic     fpga_cs_n_i,
   input  logic     fpga_mosi_i,
   output logic     fpga_miso_o
);

   sd_bus_t boot_bus;
   sd_bus_t fpga_bus;
   sd_bus_t pin_bus;
   byte_t   ld_byte;    // Reader to loader stream
   logic    ld_valid;
   logic    ld_ready;
   logic    rd_enable;

   assign fpga_bus = '{sclk: fpga_sclk_i, cs_n: fpga_cs_n_i, mosi: fpga_mosi_i,
                       miso: sd_miso_i};

   ////////////////////////////////////////
   // Boot engine and loader
   ////////////////////////////////////////

   sd_read_ctrl u_read (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .enable_i     (rd_enable),
      .set_sel_i    (set_sel_i),
      .cfg_done_i   (cfg_done_i),
      .sink_ready_i (ld_ready),
      .byte_o       (ld_byte),
      .byte_valid_o (ld_valid),
      .detached_o   (detached_o),
      .bus_o        (boot_bus),
      .miso_i       (pin_bus.miso)
   );

   cfg_loader u_loader (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .byte_i        (ld_byte),
      .byte_valid_i  (ld_valid),
      .ready_o       (ld_ready),
      .cfg_init_n_i  (cfg_init_n_i),
      .config_n_o    (config_n_o),
      .cfg_clk_o     (cfg_clk_o),
      .cfg_dat_o     (cfg_dat_o),
      .read_enable_o (rd_enable)
   );

   sd_bus_arbiter u_arb (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .takeover_i (takeover_i),
      .detached_i (detached_o),
      .boot_bus_i (boot_bus),
      .fpga_bus_i (fpga_bus),
      .sd_bus_o   (pin_bus),
      .miso_i     (sd_miso_i),
      .granted_o  ()            // Pins already show the owner
   );

   assign sd_sclk_o   = pin_bus.sclk;
   assign sd_cs_n_o   = pin_bus.cs_n;
   assign sd_mosi_o   = pin_bus.mosi;
   assign fpga_miso_o = pin_bus.miso;

endmodule

/* bench/sd_card_model.sv */
`include "boot_config.svh"

module sd_card_model
   import boot_pkg::*;
(
   input  logic sclk_i,
   input  logic cs_n_i,
   input  logic mosi_i,
   output logic miso_o
);

   timeunit 1ns;
   timeprecision 1ps;

   byte_t resp_q[$];  // Bytes waiting to go out on miso
   byte_t cmd[6];     // Command frame being collected
   byte_t rx_sh;
   byte_t tx_sh;
   int    bit_cnt;
   int    cmd_cnt;

   // Image content, block blk, offset idx
   function automatic byte_t card_byte(input blk_addr_t blk, input int idx);
      blk_addr_t mix;
      mix = blk ^ (blk >> 11) ^ (blk >> 7);
      return byte_t'(mix * 29 + idx * 7 + (idx >> 8) * 101);
   endfunction

   ////////////////////////////////////////
   // Command decode
   ////////////////////////////////////////

   task automatic queue_response();
      blk_addr_t addr;
      int        k;
      addr = {cmd[1], cmd[2], cmd[3], cmd[4]};
      resp_q.delete();
      resp_q.push_back(8'hff);              // One byte of Ncr
      case (cmd[0][5:0])
         6'd0: resp_q.push_back(8'h01);    // R1, in idle state
         6'd17: begin
            resp_q.push_back(8'h00);
            // Access time differs from block to block
            for (k = 0; k <= addr % 4; k++) resp_q.push_back(8'hff);
            resp_q.push_back(8'hfe);        // Start token
            for (k = 0; k < `BOOT_BLOCK_BYTES; k++) resp_q.push_back(card_byte(addr, k));
            resp_q.push_back(8'h5a);        // CRC, never checked
            resp_q.push_back(8'h3c);
         end
         default: resp_q.push_back(8'h05);  // Illegal command
      endcase
   endtask

   task automatic take_byte(input byte_t b);
      if (cmd_cnt == 0 && b[7:6] == 2'b01) begin
         cmd[0]  = b;                       // Start and transmission bits
         cmd_cnt = 1;
      end else if (cmd_cnt > 0) begin
         cmd[cmd_cnt] = b;
         cmd_cnt++;
         if (cmd_cnt == 6) begin
            cmd_cnt = 0;
            queue_response();
         end
      end
   endtask

   ////////////////////////////////////////
   // SPI mode 0 line handling
   ////////////////////////////////////////

   initial begin
      miso_o  = 1'b1;
      tx_sh   = 8'hff;
      bit_cnt = 0;
      cmd_cnt = 0;
   end

   // Deselect drops any transfer in progress
   always @(posedge cs_n_i) begin
      resp_q.delete();
      bit_cnt = 0;
      cmd_cnt = 0;
      tx_sh   = 8'hff;
      miso_o  = 1'b1;
   end

   always @(posedge sclk_i) begin
      if (!cs_n_i) begin
         rx_sh   = {rx_sh[6:0], mosi_i};   // Host data valid on rising edge
         bit_cnt = bit_cnt + 1;
         if (bit_cnt == 8) begin
            bit_cnt = 0;
            take_byte(rx_sh);
         end
      end
   end

   always @(negedge sclk_i) begin
      if (!cs_n_i) begin
         if (bit_cnt == 0) begin
            tx_sh = 8'hff;                 // Idle filler
            if (resp_q.size() > 0) tx_sh = resp_q.pop_front();
         end else begin
            tx_sh = {tx_sh[6:0], 1'b1};
         end
         miso_o = tx_sh[7];                // Next bit, MSB first
      end
   end

endmodule

/* bench/boot_cpld_tb.sv */
`include "boot_config.svh"

module boot_cpld_tb
   import boot_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int done_bytes = 2 * `BOOT_BLOCK_BYTES + 100;  // Past the second block
   localparam int run_cycles = (done_bytes + 200) * 16 * `BOOT_SPI_DIV * 2;
   localparam int limit_ns   = (2 * run_cycles + 20000) * 10;  // Two boots plus margin

   logic      clk;
   logic      reset;
   set_sel_t  set_sel;
   logic      sd_sclk;
   logic      sd_cs_n;
   logic      sd_mosi;
   logic      sd_miso;
   logic      cfg_init_n;
   logic      cfg_done;
   logic      config_n;
   logic      cfg_clk;
   logic      cfg_dat;
   logic      detached;
   logic      takeover;
   sd_bus_t   fpga_drv;    // FPGA side of the card, miso member unused
   logic      fpga_miso;

   byte_t     cap_q[$];    // Bytes seen by the FPGA model
   byte_t     cap_sh;
   int        cap_bits;
   int        cap_total;
   int        cmp_idx;
   int        cmp_test;    // Test that owns the stream check
   blk_addr_t start_blk;
   int        errs[1:6];
   int        n_fail;

   boot_cpld dut_i (
      .clk_i        (clk),
      .reset_i      (reset),
      .set_sel_i    (set_sel),
      .sd_sclk_o    (sd_sclk),
      .sd_cs_n_o    (sd_cs_n),
      .sd_mosi_o    (sd_mosi),
      .sd_miso_i    (sd_miso),
      .cfg_init_n_i (cfg_init_n),
      .cfg_done_i   (cfg_done),
      .config_n_o   (config_n),
      .cfg_clk_o    (cfg_clk),
      .cfg_dat_o    (cfg_dat),
      .detached_o   (detached),
      .takeover_i   (takeover),
      .fpga_sclk_i  (fpga_drv.sclk),
      .fpga_cs_n_i  (fpga_drv.cs_n),
      .fpga_mosi_i  (fpga_drv.mosi),
      .fpga_miso_o  (fpga_miso)
   );

   sd_card_model card_i (
      .sclk_i (sd_sclk),
      .cs_n_i (sd_cs_n),
      .mosi_i (sd_mosi),
      .miso_o (sd_miso)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Expected card byte, block blk, offset idx
   function automatic byte_t expected_byte(input blk_addr_t blk, input int idx);
      blk_addr_t mix;
      mix = blk ^ (blk >> 11) ^ (blk >> 7);
      return byte_t'(mix * 29 + idx * 7 + (idx >> 8) * 101);
   endfunction

   task automatic report_mismatch(input int test, input string name,
                                  input logic [31:0] exp_v, input logic [31:0] got_v);
      $display("Mismatch %s: expected 0x%0h, got 0x%0h (test %0d, %0t)",
               name, exp_v, got_v, test, $time);
      errs[test]++;
   endtask

   task automatic report_failure(input int test, input string what);
      $display("Error in test %0d: %s (%0t)", test, what, $time);
      errs[test]++;
   endtask

   task automatic finish_test(input int test, input string title);
      if (errs[test] == 0) begin
         $display("Test %0d %s: pass", test, title);
      end else begin
         $display("Test %0d %s: FAIL, %0d errors", test, title, errs[test]);
      end
   endtask

   ////////////////////////////////////////
   // FPGA model and stream compare
   ////////////////////////////////////////

   always @(posedge cfg_clk) begin
      cap_sh = {cap_sh[6:0], cfg_dat};     // MSB arrives first
      cap_bits++;
      if (cap_bits == 8) begin
         cap_bits = 0;
         cap_q.push_back(cap_sh);
         cap_total++;
      end
   end

   always @(negedge clk) begin
      byte_t got_b;
      byte_t exp_b;
      while (cap_q.size() > 0) begin
         got_b = cap_q.pop_front();
         exp_b = expected_byte(start_blk + cmp_idx / `BOOT_BLOCK_BYTES,
                               cmp_idx % `BOOT_BLOCK_BYTES);
         if (got_b !== exp_b) report_mismatch(cmp_test, "cfg_dat_o", exp_b, got_b);
         cmp_idx++;
      end
   end

   ////////////////////////////////////////
   // Test tasks
   ////////////////////////////////////////

   // Reset through detach, one full boot
   task automatic boot_run(input int t_rst, input int t_init, input int t_strm,
                           input int t_det, input bit announce);
      int n;
      int delay;
      reset      <= 1'b1;
      cfg_init_n <= 1'b0;                  // FPGA busy clearing
      cfg_done   <= 1'b0;
      repeat (8) @(posedge clk);
      cap_q.delete();
      cap_bits  = 0;
      cap_total = 0;
      cmp_idx   = 0;
      cmp_test  = t_strm;
      start_blk = blk_addr_t'(set_sel) * `BOOT_IMG_BLOCKS;
      reset <= 1'b0;
      @(negedge clk);
      if (config_n !== 1'b0) report_mismatch(t_rst, "config_n_o", 0, config_n);
      if (sd_cs_n !== 1'b1) report_mismatch(t_rst, "sd_cs_n_o", 1, sd_cs_n);
      if (sd_sclk !== 1'b0) report_mismatch(t_rst, "sd_sclk_o", 0, sd_sclk);
      if (cfg_clk !== 1'b0) report_mismatch(t_rst, "cfg_clk_o", 0, cfg_clk);
      if (detached !== 1'b0) report_mismatch(t_rst, "detached_o", 0, detached);
      n = 0;
      while (config_n === 1'b0 && n < 4 * `BOOT_PROG_CYCLES) begin
         n++;
         @(negedge clk);
      end
      if (n != `BOOT_PROG_CYCLES) begin
         report_failure(t_rst, $sformatf("config_n_o stayed low %0d cycles instead of %0d",
                                         n, `BOOT_PROG_CYCLES));
      end
      if (announce) finish_test(t_rst, "reset state and program pulse");

      // Init held low, engine must stay quiet
      delay = 20 + $urandom % 80;
      @(posedge clk);
      if (announce) begin
         takeover <= 1'b1;                 // Too early, must be ignored
         fpga_drv <= '{sclk: 1'b1, cs_n: 1'b0, mosi: 1'b0, miso: 1'b0};
      end
      for (n = 0; n < delay; n++) begin
         @(negedge clk);
         if (sd_sclk !== 1'b0) report_mismatch(t_init, "sd_sclk_o", 0, sd_sclk);
         if (cfg_clk !== 1'b0) report_mismatch(t_init, "cfg_clk_o", 0, cfg_clk);
         if (takeover && sd_cs_n !== 1'b1) report_mismatch(5, "sd_cs_n_o", 1, sd_cs_n);
         if (takeover && sd_mosi !== 1'b1) report_mismatch(5, "sd_mosi_o", 1, sd_mosi);
      end
      @(posedge clk);
      takeover   <= 1'b0;
      fpga_drv   <= '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b1, miso: 1'b0};
      cfg_init_n <= 1'b1;
      if (announce) finish_test(t_init, "quiet while init low");

      // FPGA signals done after enough bytes
      while (cap_total < done_bytes) @(negedge clk);
      @(posedge clk);
      cfg_done <= 1'b1;
      n = 0;
      while (detached !== 1'b1 && n < 64 * `BOOT_SPI_DIV) begin
         @(negedge clk);
         n++;
      end
      if (detached !== 1'b1) report_failure(t_det, "detached_o did not rise after cfg_done_i");
      for (n = 0; n < 100; n++) begin
         @(negedge clk);
         if (sd_cs_n !== 1'b1) report_mismatch(t_det, "sd_cs_n_o", 1, sd_cs_n);
         if (sd_sclk !== 1'b0) report_mismatch(t_det, "sd_sclk_o", 0, sd_sclk);
      end
      if (cmp_idx < done_bytes) begin
         report_failure(t_strm, $sformatf("only %0d config bytes arrived", cmp_idx));
      end
      if (announce) begin
         finish_test(t_strm, "stream across block boundary");
         finish_test(t_det, "release after done");
      end
   endtask

   // Bit-banged byte on the FPGA pass-through pins
   task automatic fpga_spi_byte(input byte_t tx, output byte_t rx);
      int b;
      for (b = 7; b >= 0; b--) begin
         @(posedge clk);
         fpga_drv.mosi <= tx[b];
         @(posedge clk);
         fpga_drv.sclk <= 1'b1;
         @(negedge clk);
         if (sd_sclk !== fpga_drv.sclk) report_mismatch(5, "sd_sclk_o", fpga_drv.sclk, sd_sclk);
         if (sd_cs_n !== fpga_drv.cs_n) report_mismatch(5, "sd_cs_n_o", fpga_drv.cs_n, sd_cs_n);
         if (sd_mosi !== fpga_drv.mosi) report_mismatch(5, "sd_mosi_o", fpga_drv.mosi, sd_mosi);
         if (fpga_miso !== sd_miso) report_mismatch(5, "fpga_miso_o", sd_miso, fpga_miso);
         rx[b] = fpga_miso;
         @(posedge clk);
         fpga_drv.sclk <= 1'b0;
      end
   endtask

   // FPGA owns the card, CMD0 through the arbiter
   task automatic takeover_check();
      logic [47:0] frame;
      byte_t       rx;
      int          k;
      frame = {8'h40, 32'h0, 8'h95};
      @(posedge clk);
      takeover <= 1'b1;
      @(posedge clk);
      fpga_drv.cs_n <= 1'b0;
      for (k = 0; k < 6; k++) fpga_spi_byte(frame[47 - 8 * k -: 8], rx);
      k  = 0;
      rx = 8'hff;
      while (rx === 8'hff && k < 8) begin
         fpga_spi_byte(8'hff, rx);
         k++;
      end
      if (rx !== 8'h01) report_mismatch(5, "fpga_miso_o", 8'h01, rx);
      @(posedge clk);
      fpga_drv.cs_n <= 1'b1;
   endtask

   ////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////

   initial begin
      void'($urandom(32'hd6db));
      errs       = '{default: 0};
      reset      <= 1'b1;
      cfg_init_n <= 1'b0;
      cfg_done   <= 1'b0;
      takeover   <= 1'b0;
      fpga_drv   <= '{sclk: 1'b0, cs_n: 1'b1, mosi: 1'b1, miso: 1'b0};
      set_sel    <= set_sel_t'($urandom % 16);
      boot_run(1, 2, 3, 4, 1'b1);
      takeover_check();
      finish_test(5, "takeover only after detach");

      @(posedge clk);
      takeover <= 1'b0;
      set_sel  <= set_sel_t'(set_sel + 1 + $urandom % 15);  // Any other set
      boot_run(6, 6, 6, 6, 1'b0);
      finish_test(6, "second boot from another set");

      n_fail = 0;
      foreach (errs[t]) if (errs[t] != 0) n_fail++;
      $display("Tests run: 6, passed: %0d, failed: %0d", 6 - n_fail, n_fail);
      if (n_fail == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      #(limit_ns);
      $display("Timeout: the run did not finish within %0d ns", limit_ns);
      $display("Some tests failed");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+logic
logic/boot_pkg.sv
logic/spi_shifter.sv
logic/sd_read_ctrl.sv
logic/cfg_loader.sv
logic/sd_bus_arbiter.sv
logic/boot_cpld.sv
bench/sd_card_model.sv
bench/boot_cpld_tb.sv
